// ==== rtl/exec_pkg.sv ====
package exec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // Base integer funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // M extension funct3, divides left out
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;

    localparam int MUL_STEPS = 32;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU
    } exec_op_e;

    // R and I views of the same instruction word
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } insn_word_u;

    function automatic logic is_mul_op(exec_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
    endfunction

endpackage

// ==== rtl/reg_file.sv ====
module reg_file import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 1; n < NUM_REGS; n++) begin
                regs[n] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== rtl/alu_unit.sv ====
module alu_unit import exec_pkg::*; (
    input  exec_op_e        ex_op,
    input  logic [XLEN-1:0] ex_a,
    input  logic [XLEN-1:0] ex_b,
    output logic [XLEN-1:0] alu_result
);

    logic [4:0] shamt;

    assign shamt = ex_b[4:0];

    always_comb begin
        case (ex_op)
            OP_ADD: begin
                alu_result = ex_a + ex_b;
            end
            OP_SUB: begin
                alu_result = ex_a - ex_b;
            end
            OP_AND: begin
                alu_result = ex_a & ex_b;
            end
            OP_OR: begin
                alu_result = ex_a | ex_b;
            end
            OP_XOR: begin
                alu_result = ex_a ^ ex_b;
            end
            OP_SLL: begin
                alu_result = ex_a << shamt;
            end
            OP_SRL: begin
                alu_result = ex_a >> shamt;
            end
            OP_SRA: begin
                alu_result = $signed(ex_a) >>> shamt;
            end
            OP_SLT: begin
                alu_result = {{(XLEN-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};
            end
            OP_SLTU: begin
                alu_result = {{(XLEN-1){1'b0}}, ex_a < ex_b};
            end
            // Multiplies and no-ops
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

// ==== rtl/mul_unit.sv ====
module mul_unit import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ex_valid,
    input  exec_op_e              ex_op,
    input  logic [XLEN-1:0]       ex_a,
    input  logic [XLEN-1:0]       ex_b,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    output logic                  busy,
    output logic                  mul_done,
    output logic [XLEN-1:0]       mul_result,
    output logic [REG_ADDR_W-1:0] mul_rd
);

    logic                         start;
    logic                         running;
    logic [$clog2(MUL_STEPS)-1:0] step_cnt;
    logic                         a_signed;
    logic                         b_signed;
    logic [XLEN-1:0]              a_mag;
    logic [XLEN-1:0]              b_mag;
    logic [2*XLEN-1:0]            mcand;
    logic [XLEN-1:0]              mplier;
    logic [2*XLEN-1:0]            acc;
    logic                         neg;
    logic                         want_low;
    logic [2*XLEN-1:0]            product;

    assign start    = ex_valid && is_mul_op(ex_op);
    assign a_signed = ex_op != OP_MULHU;
    assign b_signed = ex_op == OP_MUL || ex_op == OP_MULH;
    assign a_mag    = (a_signed && ex_a[XLEN-1]) ? -ex_a : ex_a;
    assign b_mag    = (b_signed && ex_b[XLEN-1]) ? -ex_b : ex_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            step_cnt <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= running && (&step_cnt);
            if (start) begin
                running  <= 1'b1;
                step_cnt <= '0;
            end else if (running) begin
                step_cnt <= step_cnt + 1'b1;
                if (&step_cnt) begin
                    running <= 1'b0;
                end
            end
        end
    end

    // Unsigned shift-add on magnitudes, sign fixed up at the end
    always_ff @(posedge clk) begin
        if (start) begin
            mcand    <= {{XLEN{1'b0}}, a_mag};
            mplier   <= b_mag;
            acc      <= '0;
            neg      <= (a_signed && ex_a[XLEN-1]) ^ (b_signed && ex_b[XLEN-1]);
            want_low <= ex_op == OP_MUL;
            mul_rd   <= ex_rd;
        end else if (running) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product    = neg ? -acc : acc;
    assign mul_result = want_low ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];

    // Held through mul_done so a dependent issue sees the writeback bypass
    assign busy = start || running || mul_done;

endmodule

// ==== rtl/writeback_merge.sv ====
module writeback_merge import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ex_valid,
    input  exec_op_e              ex_op,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    input  logic [XLEN-1:0]       alu_result,
    input  logic                  mul_done,
    input  logic [REG_ADDR_W-1:0] mul_rd,
    input  logic [XLEN-1:0]       mul_result,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data
);

    logic alu_fin;

    assign alu_fin = ex_valid && !is_mul_op(ex_op);

    // Issue rule keeps the two sources apart
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (alu_fin) begin
            wb_valid <= ex_rd != '0;
        end else if (mul_done) begin
            wb_valid <= mul_rd != '0;
        end else begin
            wb_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_fin) begin
            wb_rd   <= ex_rd;
            wb_data <= alu_result;
        end else if (mul_done) begin
            wb_rd   <= mul_rd;
            wb_data <= mul_result;
        end
    end

endmodule

// ==== rtl/issue_stage.sv ====
module issue_stage import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  insn_valid,
    input  insn_word_u            insn,
    input  logic [XLEN-1:0]       alu_result,
    input  logic                  wb_valid,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [XLEN-1:0]       wb_data,
    output logic                  ex_valid,
    output exec_op_e              ex_op,
    output logic [XLEN-1:0]       ex_a,
    output logic [XLEN-1:0]       ex_b,
    output logic [REG_ADDR_W-1:0] ex_rd
);

    exec_op_e        dec_op;
    logic            dec_we;
    logic            use_imm;
    logic            alt;
    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] rf_rdata1;
    logic [XLEN-1:0] rf_rdata2;
    logic            fwd_ex1, fwd_ex2;
    logic            fwd_wb1, fwd_wb2;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;

    reg_file reg_file_i (
        .clk    (clk),
        .rst    (rst),
        .rs1    (insn.r.rs1),
        .rs2    (insn.r.rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_valid),
        .waddr  (wb_rd),
        .wdata  (wb_data)
    );

    assign imm_sext = {{(XLEN-12){insn.i.imm12[11]}}, insn.i.imm12};

    always_comb begin
        dec_op  = OP_NOP;
        use_imm = 1'b0;
        alt     = 1'b0;
        if (insn.r.opcode == OPC_OP && insn.r.funct7 == FUNCT7_MULDIV) begin
            case (insn.r.funct3)
                F3_MUL:    dec_op = OP_MUL;
                F3_MULH:   dec_op = OP_MULH;
                F3_MULHSU: dec_op = OP_MULHSU;
                F3_MULHU:  dec_op = OP_MULHU;
                default:   dec_op = OP_NOP;
            endcase
        end else if (insn.i.opcode == OPC_OP_IMM ||
                     (insn.r.opcode == OPC_OP &&
                      (insn.r.funct7 == '0 || insn.r.funct7 == FUNCT7_ALT))) begin
            use_imm = insn.i.opcode == OPC_OP_IMM;
            // No SUBI, so only shifts see the alternate bit in I form
            if (use_imm) begin
                alt = insn.i.funct3 == F3_SRL_SRA && insn.i.imm12[10];
            end else begin
                alt = insn.r.funct7 == FUNCT7_ALT;
            end
            case (insn.i.funct3)
                F3_ADD_SUB: dec_op = alt ? OP_SUB : OP_ADD;
                F3_SLL:     dec_op = OP_SLL;
                F3_SLT:     dec_op = OP_SLT;
                F3_SLTU:    dec_op = OP_SLTU;
                F3_XOR:     dec_op = OP_XOR;
                F3_SRL_SRA: dec_op = alt ? OP_SRA : OP_SRL;
                F3_OR:      dec_op = OP_OR;
                F3_AND:     dec_op = OP_AND;
                default:    dec_op = OP_NOP;
            endcase
        end
    end

    assign dec_we = dec_op != OP_NOP && insn.r.rd != '0;

    // Execute result wins over writeback
    assign fwd_ex1 = ex_valid && insn.r.rs1 != '0 && ex_rd == insn.r.rs1;
    assign fwd_ex2 = ex_valid && insn.r.rs2 != '0 && ex_rd == insn.r.rs2;
    assign fwd_wb1 = wb_valid && insn.r.rs1 != '0 && wb_rd == insn.r.rs1;
    assign fwd_wb2 = wb_valid && insn.r.rs2 != '0 && wb_rd == insn.r.rs2;

    assign rs1_val = fwd_ex1 ? alu_result : (fwd_wb1 ? wb_data : rf_rdata1);
    assign rs2_val = fwd_ex2 ? alu_result : (fwd_wb2 ? wb_data : rf_rdata2);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_op    <= OP_NOP;
            ex_rd    <= '0;
        end else if (insn_valid) begin
            ex_valid <= dec_op != OP_NOP;
            ex_op    <= dec_op;
            ex_rd    <= dec_we ? insn.r.rd : '0;
        end else begin
            ex_valid <= 1'b0;
            ex_op    <= OP_NOP;
            ex_rd    <= '0;
        end
    end

    always_ff @(posedge clk) begin
        ex_a <= rs1_val;
        ex_b <= use_imm ? imm_sext : rs2_val;
    end

endmodule

// ==== rtl/int_exec_core.sv ====
module int_exec_core import exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  insn_valid,
    input  insn_word_u            insn,
    output logic                  busy,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data
);

    logic                  ex_valid;
    exec_op_e              ex_op;
    logic [XLEN-1:0]       ex_a;
    logic [XLEN-1:0]       ex_b;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [XLEN-1:0]       alu_result;
    logic                  mul_done;
    logic [XLEN-1:0]       mul_result;
    logic [REG_ADDR_W-1:0] mul_rd;

    issue_stage issue_stage_i (
        .clk        (clk),
        .rst        (rst),
        .insn_valid (insn_valid),
        .insn       (insn),
        .alu_result (alu_result),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .ex_valid   (ex_valid),
        .ex_op      (ex_op),
        .ex_a       (ex_a),
        .ex_b       (ex_b),
        .ex_rd      (ex_rd)
    );

    alu_unit alu_unit_i (
        .ex_op      (ex_op),
        .ex_a       (ex_a),
        .ex_b       (ex_b),
        .alu_result (alu_result)
    );

    mul_unit mul_unit_i (
        .clk        (clk),
        .rst        (rst),
        .ex_valid   (ex_valid),
        .ex_op      (ex_op),
        .ex_a       (ex_a),
        .ex_b       (ex_b),
        .ex_rd      (ex_rd),
        .busy       (busy),
        .mul_done   (mul_done),
        .mul_result (mul_result),
        .mul_rd     (mul_rd)
    );

    writeback_merge writeback_merge_i (
        .clk        (clk),
        .rst        (rst),
        .ex_valid   (ex_valid),
        .ex_op      (ex_op),
        .ex_rd      (ex_rd),
        .alu_result (alu_result),
        .mul_done   (mul_done),
        .mul_rd     (mul_rd),
        .mul_result (mul_result),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

// ==== sim/int_exec_core_properties.sv ====
module int_exec_core_properties import exec_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  insn_valid,
    input insn_word_u            insn,
    input logic                  busy,
    input logic                  wb_valid,
    input logic [REG_ADDR_W-1:0] wb_rd
);

    timeunit 1ns;
    timeprecision 100ps;

    logic                  alu_strobe;
    logic [REG_ADDR_W-1:0] rd_d1;
    logic [REG_ADDR_W-1:0] rd_d2;

    // Kept arithmetic forms that write a real register
    assign alu_strobe = insn_valid && insn.r.rd != '0 &&
                        (insn.i.opcode == OPC_OP_IMM ||
                         (insn.r.opcode == OPC_OP &&
                          (insn.r.funct7 == '0 || insn.r.funct7 == FUNCT7_ALT)));

    always_ff @(posedge clk) begin
        rd_d1 <= insn.r.rd;
        rd_d2 <= rd_d1;
    end

    no_strobe_when_busy: assert property (@(posedge clk) disable iff (rst)
        !(insn_valid && busy))
        else $error("instruction strobed while busy is high");

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_rd != '0)
        else $error("writeback to register zero");

    alu_wb_two_edges: assert property (@(posedge clk) disable iff (rst)
        alu_strobe |-> ##2 (wb_valid && wb_rd == rd_d2))
        else $error("ALU writeback missing two edges after its strobe");

endmodule

// ==== sim/tb_int_exec_core.sv ====
module tb_int_exec_core import exec_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int MUL_LATENCY    = 34;

    logic                  clk;
    logic                  rst;
    logic                  insn_valid;
    insn_word_u            insn;
    logic                  busy;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    logic [XLEN-1:0]       ref_regs [NUM_REGS];
    logic [REG_ADDR_W-1:0] exp_rd [$];
    logic [XLEN-1:0]       exp_data [$];
    int                    seed = 13794;
    int                    cycles = 0;
    int                    errors = 0;

    int_exec_core int_exec_core_i (
        .clk        (clk),
        .rst        (rst),
        .insn_valid (insn_valid),
        .insn       (insn),
        .busy       (busy),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    bind int_exec_core int_exec_core_properties int_exec_core_properties_i (
        .clk        (clk),
        .rst        (rst),
        .insn_valid (insn_valid),
        .insn       (insn),
        .busy       (busy),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no end of test within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0d ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Each writeback must match the oldest pending result
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            assert (exp_rd.size() > 0)
                else report_error($sformatf("writeback to x%0d with nothing pending", wb_rd));
            assert (wb_rd == exp_rd[0] && wb_data == exp_data[0])
                else report_error($sformatf("got x%0d = %h, expected x%0d = %h",
                                            wb_rd, wb_data, exp_rd[0], exp_data[0]));
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
        end
    end

    function automatic logic [31:0] encode(input exec_op_e op, input bit use_imm,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [11:0] imm);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        f7 = (op inside {OP_SUB, OP_SRA}) ? 7'b0100000 : 7'b0000000;
        case (op)
            OP_SLL, OP_MULH:   f3 = 3'b001;
            OP_SLT, OP_MULHSU: f3 = 3'b010;
            OP_SLTU, OP_MULHU: f3 = 3'b011;
            OP_XOR:            f3 = 3'b100;
            OP_SRL, OP_SRA:    f3 = 3'b101;
            OP_OR:             f3 = 3'b110;
            OP_AND:            f3 = 3'b111;
            default:           f3 = 3'b000;
        endcase
        if (op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU}) begin
            f7 = 7'b0000001;
        end
        // Shift immediates keep funct7 in the top of imm12
        imm12 = (f3 == 3'b001 || f3 == 3'b101) ? {f7, imm[4:0]} : imm;
        return use_imm ? {imm12, rs1, f3, rd, 7'b0010011} : {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] model(input exec_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ub;
        logic [63:0]        p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ub = {32'd0, b};
        p  = '0;
        case (op)
            OP_ADD:          return a + b;
            OP_SUB:          return a - b;
            OP_AND:          return a & b;
            OP_OR:           return a | b;
            OP_XOR:          return a ^ b;
            OP_SLL:          return a << b[4:0];
            OP_SRL:          return a >> b[4:0];
            OP_SRA:          return $signed(a) >>> b[4:0];
            OP_SLT:          return {31'd0, $signed(a) < $signed(b)};
            OP_SLTU:         return {31'd0, a < b};
            OP_MUL, OP_MULH: p = sa * sb;
            OP_MULHSU:       p = sa * $signed(ub);
            OP_MULHU:        p = {32'd0, a} * ub;
            default:         return '0;
        endcase
        return (op == OP_MUL) ? p[31:0] : p[63:32];
    endfunction

    task automatic issue(input logic [31:0] word);
        while (busy) begin
            insn_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        insn_valid = 1'b1;
        insn       = word;
        @(posedge clk);
        #1;
        insn_valid = 1'b0;
    endtask

    task automatic run_op(input exec_op_e op, input bit use_imm, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] imm);
        logic [31:0] word;
        logic [31:0] b;
        logic [31:0] res;
        word = encode(op, use_imm, rd, rs1, rs2, imm);
        b    = use_imm ? {{20{word[31]}}, word[31:20]} : ref_regs[rs2];
        res  = model(op, ref_regs[rs1], b);
        if (rd != 5'd0) begin
            ref_regs[rd] = res;
            exp_rd.push_back(rd);
            exp_data.push_back(res);
        end
        issue(word);
    endtask

    // 11 + 11 + 10 bits built from immediates that stay positive
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
        run_op(OP_ADD, 1'b1, rd, 5'd0, 5'd0, {1'b0, v[31:21]});
        run_op(OP_SLL, 1'b1, rd, rd, 5'd0, 12'd11);
        run_op(OP_OR, 1'b1, rd, rd, 5'd0, {1'b0, v[20:10]});
        run_op(OP_SLL, 1'b1, rd, rd, 5'd0, 12'd10);
        run_op(OP_OR, 1'b1, rd, rd, 5'd0, {2'b0, v[9:0]});
    endtask

    task automatic drain();
        while (exp_rd.size() > 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic reset_then_add_zero();
        rst        = 1'b1;
        insn_valid = 1'b0;
        insn       = '0;
        foreach (ref_regs[n]) begin
            ref_regs[n] = '0;
        end
        repeat (5) begin
            @(posedge clk);
            #1;
            if (cycles >= 3) begin
                rst = 1'b0;
            end
            assert (!wb_valid && !busy)
                else report_error("wb_valid or busy high during or right after reset");
        end
        run_op(OP_ADD, 1'b0, 5'd3, 5'd1, 5'd2, 12'd0);
        drain();
    endtask

    task automatic alu_ops_random();
        exec_op_e    op;
        logic [31:0] r;
        repeat (2) begin
            // ALU ops are enum codes 1 to 10
            for (int i = 1; i <= 10; i++) begin
                op = exec_op_e'(i);
                r  = $random(seed);
                load_reg(5'd1, $random(seed));
                load_reg(5'd2, $random(seed));
                run_op(op, 1'b0, 5'd3, 5'd1, 5'd2, 12'd0);
                if (op != OP_SUB) begin
                    run_op(op, 1'b1, 5'd4, 5'd1, 5'd0, r[11:0]);
                end
            end
        end
        drain();
    endtask

    task automatic dependent_chains();
        exec_op_e    op;
        bit          use_imm;
        logic [4:0]  rd;
        logic [4:0]  prev1;
        logic [4:0]  prev2;
        logic [31:0] r;
        load_reg(5'd3, $random(seed));
        load_reg(5'd4, $random(seed));
        prev2 = 5'd3;
        prev1 = 5'd4;
        for (int i = 0; i < 40; i++) begin
            op      = exec_op_e'(1 + i % 10);
            use_imm = (i % 4 == 3) && op != OP_SUB;
            rd      = 5'(5 + i % 6);
            r       = $random(seed);
            run_op(op, use_imm, rd, prev1, prev2, r[11:0]);
            prev2 = prev1;
            prev1 = rd;
        end
        drain();
    endtask

    task automatic check_mul(input exec_op_e op, input logic [31:0] a, input logic [31:0] b);
        int lat;
        load_reg(5'd1, a);
        load_reg(5'd2, b);
        drain();
        lat = 0;
        run_op(op, 1'b0, 5'd7, 5'd1, 5'd2, 12'd0);
        while (!wb_valid) begin
            assert (busy) else report_error("busy low before the multiply result");
            @(posedge clk);
            #1;
            lat++;
        end
        assert (lat == MUL_LATENCY && !busy)
            else report_error($sformatf("multiply took %0d cycles or busy stayed high", lat));
        // Needs the product from the writeback bypass
        run_op(OP_ADD, 1'b0, 5'd8, 5'd7, 5'd1, 12'd0);
    endtask

    task automatic multiply_ops();
        exec_op_e    op;
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 4; i++) begin
            op = exec_op_e'(11 + i);
            a  = $random(seed);
            b  = $random(seed);
            check_mul(op, a, b);
            check_mul(op, a | 32'h8000_0000, b | 32'h8000_0000);
            check_mul(op, 32'h8000_0000, 32'h8000_0000);
            check_mul(op, 32'hffff_ffff, 32'h7fff_ffff);
            check_mul(op, 32'h8000_0000, 32'hffff_ffff);
        end
        drain();
    endtask

    task automatic x0_and_unsupported();
        load_reg(5'd1, $random(seed));
        load_reg(5'd2, $random(seed));
        run_op(OP_ADD, 1'b0, 5'd0, 5'd1, 5'd2, 12'd0);
        run_op(OP_MUL, 1'b0, 5'd0, 5'd1, 5'd2, 12'd0);
        // Load, LUI and DIV words
        issue({12'h123, 5'd1, 3'b010, 5'd5, 7'b0000011});
        issue({20'h12345, 5'd6, 7'b0110111});
        issue({7'b0000001, 5'd2, 5'd1, 3'b100, 5'd9, 7'b0110011});
        run_op(OP_OR, 1'b0, 5'd10, 5'd0, 5'd1, 12'd0);
        run_op(OP_ADD, 1'b0, 5'd11, 5'd0, 5'd0, 12'd0);
        drain();
    endtask

    initial begin
        reset_then_add_zero();
        alu_ops_random();
        dependent_chains();
        multiply_ops();
        x0_and_unsupported();
        if (errors == 0 && exp_rd.size() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
rtl/exec_pkg.sv
rtl/reg_file.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/writeback_merge.sv
rtl/issue_stage.sv
rtl/int_exec_core.sv
sim/int_exec_core_properties.sv
sim/tb_int_exec_core.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_int_exec_core -f list.f -o tb_sim || exit 1
./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1
[ "$sim_status" -eq 0 ] || exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0
